/* hdc_pkg.sv */
`default_nettype none

package hdc_pkg;

    // ======================================================================
    // widths
    // ======================================================================

    // one xorshift word per hypervector
    localparam int DIM     = 32;
    localparam int INDEX_W = 8;
    // ones counter per dimension, packets up to 255 beats
    localparam int CNT_W   = 8;

    typedef logic [DIM-1:0]     hv_t;
    typedef logic [INDEX_W-1:0] index_t;

    // ======================================================================
    // register map
    // ======================================================================

    // word offsets, taken from byte address bits [11:2]
    localparam logic [9:0] REG_CTRL  = 10'd0;
    localparam logic [9:0] REG_COUNT = 10'd1;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // one 32-bit register word, seen as ctrl or as count
    typedef union packed {
        struct packed {
            logic [29:0] rsvd;
            logic        run;
            logic        gen;
        } ctrl;
        struct packed {
            logic [31-INDEX_W:0] rsvd;
            index_t              items;
        } count;
    } csr_word_u;

endpackage

`default_nettype wire

/* hdc_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_regs (
    input  logic            AXIS_ACLK,
    input  logic            S_AXI_ARESETN,
    input  logic [31:0]     S_AXI_AWADDR,
    input  logic            S_AXI_AWVALID,
    output logic            S_AXI_AWREADY,
    input  logic [31:0]     S_AXI_WDATA,
    input  logic [3:0]      S_AXI_WSTRB,
    input  logic            S_AXI_WVALID,
    output logic            S_AXI_WREADY,
    output logic [1:0]      S_AXI_BRESP,
    output logic            S_AXI_BVALID,
    input  logic            S_AXI_BREADY,
    input  logic [31:0]     S_AXI_ARADDR,
    input  logic            S_AXI_ARVALID,
    output logic            S_AXI_ARREADY,
    output logic [31:0]     S_AXI_RDATA,
    output logic [1:0]      S_AXI_RRESP,
    output logic            S_AXI_RVALID,
    input  logic            S_AXI_RREADY,
    input  logic            gen_done,
    output logic            run,
    output logic            gen,
    output hdc_pkg::index_t item_count
);
    import hdc_pkg::*;

    // bus states
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_AW   = 3'd1;
    localparam logic [2:0] ST_W    = 3'd2;
    localparam logic [2:0] ST_AWW  = 3'd3;
    localparam logic [2:0] ST_AR1  = 3'd4;
    localparam logic [2:0] ST_AR2  = 3'd5;

    logic [2:0] state;
    logic [9:0] wr_off;
    logic [9:0] rd_off;
    csr_word_u  wr_word;
    csr_word_u  rd_word;
    logic       wr_fire;

    // ======================================================================
    // AXI-Lite handshake
    // ======================================================================

    // write channels open in idle or while waiting for the other half
    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_W);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_AW);
    // writes win in idle so AR is only taken when no write is offered
    assign S_AXI_ARREADY = (state == ST_IDLE) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == ST_AWW);
    assign S_AXI_RVALID  = (state == ST_AR2);
    assign S_AXI_BRESP   = RESP_OKAY;
    assign S_AXI_RRESP   = RESP_OKAY;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= ST_AWW;
                    end else if (S_AXI_AWVALID) begin
                        state <= ST_AW;
                    end else if (S_AXI_WVALID) begin
                        state <= ST_W;
                    end else if (S_AXI_ARVALID) begin
                        state <= ST_AR1;
                    end
                end
                ST_AW: begin
                    if (S_AXI_WVALID) begin
                        state <= ST_AWW;
                    end
                end
                ST_W: begin
                    if (S_AXI_AWVALID) begin
                        state <= ST_AWW;
                    end
                end
                ST_AWW: begin
                    if (S_AXI_BREADY) begin
                        state <= ST_IDLE;
                    end
                end
                // one fetch cycle
                ST_AR1: state <= ST_AR2;
                ST_AR2: begin
                    if (S_AXI_RREADY) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address, data and read word capture
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            wr_off <= S_AXI_AWADDR[11:2];
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wr_word <= S_AXI_WDATA;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            rd_off <= S_AXI_ARADDR[11:2];
        end
        if (state == ST_AR1) begin
            S_AXI_RDATA <= rd_word;
        end
    end

    // ======================================================================
    // control registers
    // ======================================================================

    // commit once on the response handshake
    assign wr_fire = (state == ST_AWW) && S_AXI_BREADY;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run        <= 1'b0;
            gen        <= 1'b0;
            item_count <= '0;
        end else if (wr_fire) begin
            case (wr_off)
                REG_CTRL: begin
                    run <= wr_word.ctrl.run;
                    gen <= wr_word.ctrl.gen;
                end
                REG_COUNT: item_count <= wr_word.count.items;
                default: ;
            endcase
        end else if (gen_done) begin
            // drop back out of gen when the generator finishes
            gen <= 1'b0;
        end
    end

    // read mux where unmapped words give zero
    always_comb begin
        rd_word = '0;
        case (rd_off)
            REG_CTRL: begin
                rd_word.ctrl.run = run;
                rd_word.ctrl.gen = gen;
            end
            REG_COUNT: rd_word.count.items = item_count;
            default: rd_word = '0;
        endcase
    end

    // read data holds while the master stalls
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

`default_nettype wire

/* item_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module item_gen #(
    parameter hdc_pkg::hv_t SEED = 32'h2545_f491
) (
    input  logic            AXIS_ACLK,
    input  logic            S_AXI_ARESETN,
    input  logic            gen,
    input  hdc_pkg::index_t item_count,
    output logic            wr_en,
    output hdc_pkg::index_t wr_index,
    output hdc_pkg::hv_t    wr_vec,
    output hdc_pkg::hv_t    tie_vec,
    output logic            gen_done
);
    import hdc_pkg::*;

    hv_t    xs_q;
    hv_t    xs_next;
    index_t cnt_q;
    logic   items_left;

    // xorshift32, shifts 13 / 17 / 5
    function automatic hv_t xorshift(input hv_t x);
        hv_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign xs_next    = xorshift(xs_q);
    assign items_left = (cnt_q != item_count);

    // item k gets output k+1 after the seed
    assign wr_en    = gen && items_left;
    assign wr_index = cnt_q;
    assign wr_vec   = xs_next;

    // state reseeds whenever gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            xs_q     <= SEED;
            cnt_q    <= '0;
            gen_done <= 1'b0;
        end else if (items_left) begin
            xs_q  <= xs_next;
            cnt_q <= cnt_q + 1'b1;
        end else begin
            // one pulse, then wait for gen to drop
            gen_done <= !gen_done;
        end
    end

    // one more draw after the last item is the tie vector
    always_ff @(posedge AXIS_ACLK) begin
        if (gen && !items_left && !gen_done) begin
            tie_vec <= xs_next;
        end
    end

    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_done |=> !gen_done);

endmodule

`default_nettype wire

/* item_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module item_memory #(
    parameter int NUM_CORES  = 4,
    parameter int ITEM_DEPTH = 256
) (
    input  logic                                  AXIS_ACLK,
    input  logic                                  wr_en,
    input  hdc_pkg::index_t                       wr_index,
    input  hdc_pkg::hv_t                          wr_vec,
    input  logic [NUM_CORES*hdc_pkg::INDEX_W-1:0] rd_index,
    output logic [NUM_CORES*hdc_pkg::DIM-1:0]     rd_vec
);
    import hdc_pkg::*;

    // ======================================================================
    // item vector storage
    // ======================================================================

    // one array shared by all lanes
    hv_t mem [ITEM_DEPTH];

    // write port, fed by the generator
    always_ff @(posedge AXIS_ACLK) begin
        if (wr_en) begin
            mem[wr_index] <= wr_vec;
        end
    end

    // one registered read per lane
    // lane 0 sits in the low bits on both sides
    always_ff @(posedge AXIS_ACLK) begin
        for (int lane = 0; lane < NUM_CORES; lane++) begin
            rd_vec[lane*DIM +: DIM] <= mem[rd_index[lane*INDEX_W +: INDEX_W]];
        end
    end

endmodule

`default_nettype wire

/* bundle_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module bundle_accum #(
    parameter int NUM_CORES = 4
) (
    input  logic                                                 AXIS_ACLK,
    input  logic                                                 S_AXI_ARESETN,
    input  logic                                                 run,
    input  logic                                                 gen,
    input  logic [NUM_CORES*hdc_pkg::INDEX_W-1:0]                S_AXIS_TDATA,
    input  logic                                                 S_AXIS_TVALID,
    input  logic                                                 S_AXIS_TLAST,
    input  logic [NUM_CORES*hdc_pkg::DIM-1:0]                    rd_vec,
    input  logic                                                 done_ready,
    output logic                                                 S_AXIS_TREADY,
    output logic [NUM_CORES*hdc_pkg::INDEX_W-1:0]                rd_index,
    output logic [NUM_CORES*hdc_pkg::DIM*hdc_pkg::CNT_W-1:0]     counts,
    output logic [hdc_pkg::CNT_W-1:0]                            sample_num,
    output logic                                                 done_valid
);
    import hdc_pkg::*;

    // counters across all lanes in lane-major order
    localparam int LANE_BITS = NUM_CORES * DIM;

    logic beat_fire;
    logic look_valid;
    logic look_last;

    // ======================================================================
    // input side
    // ======================================================================

    // stall while a finished packet is pending or held
    assign S_AXIS_TREADY = run && !gen && !done_valid && !(look_valid && look_last);
    assign beat_fire     = S_AXIS_TVALID && S_AXIS_TREADY;

    // indices go straight to the memory read ports
    assign rd_index = S_AXIS_TDATA;

    // beat flags ride along with the one-cycle lookup
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            look_valid <= 1'b0;
            look_last  <= 1'b0;
        end else begin
            look_valid <= beat_fire;
            look_last  <= beat_fire && S_AXIS_TLAST;
        end
    end

    // ======================================================================
    // ones counting
    // ======================================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            counts     <= '0;
            sample_num <= '0;
            done_valid <= 1'b0;
        end else if (done_valid && done_ready) begin
            // start fresh once the packet is handed off
            counts     <= '0;
            sample_num <= '0;
            done_valid <= 1'b0;
        end else if (look_valid) begin
            // bit b of rd_vec feeds counter b
            for (int b = 0; b < LANE_BITS; b++) begin
                counts[b*CNT_W +: CNT_W] <= counts[b*CNT_W +: CNT_W] + CNT_W'(rd_vec[b]);
            end
            sample_num <= sample_num + 1'b1;
            done_valid <= look_last;
        end
    end

    // held packet keeps its counts until it is taken
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        done_valid && !done_ready |=> done_valid && $stable(counts) && $stable(sample_num));

endmodule

`default_nettype wire

/* majority_out.sv */
`timescale 1ns/1ps
`default_nettype none

module majority_out #(
    parameter int NUM_CORES = 4
) (
    input  logic                                             AXIS_ACLK,
    input  logic                                             S_AXI_ARESETN,
    input  logic [NUM_CORES*hdc_pkg::DIM*hdc_pkg::CNT_W-1:0] counts,
    input  logic [hdc_pkg::CNT_W-1:0]                        sample_num,
    input  logic                                             done_valid,
    input  hdc_pkg::hv_t                                     tie_vec,
    input  logic                                             M_AXIS_TREADY,
    output logic                                             done_ready,
    output logic [NUM_CORES*hdc_pkg::DIM-1:0]                M_AXIS_TDATA,
    output logic                                             M_AXIS_TVALID
);
    import hdc_pkg::*;

    logic [NUM_CORES*DIM-1:0] maj;

    // ======================================================================
    // majority threshold
    // ======================================================================

    // compare 2*count against sample_num, one extra bit for the doubling
    always_comb begin
        logic [CNT_W:0] twice;
        logic [CNT_W:0] limit;
        limit = {1'b0, sample_num};
        for (int lane = 0; lane < NUM_CORES; lane++) begin
            for (int d = 0; d < DIM; d++) begin
                twice = {counts[(lane*DIM+d)*CNT_W +: CNT_W], 1'b0};
                if (twice > limit) begin
                    maj[lane*DIM+d] = 1'b1;
                end else if (twice < limit) begin
                    maj[lane*DIM+d] = 1'b0;
                end else begin
                    // even count split down the middle
                    maj[lane*DIM+d] = tie_vec[d];
                end
            end
        end
    end

    // ======================================================================
    // one-entry output buffer
    // ======================================================================

    // free when empty or draining this cycle
    assign done_ready = !M_AXIS_TVALID || M_AXIS_TREADY;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            M_AXIS_TVALID <= 1'b0;
        end else if (done_valid && done_ready) begin
            M_AXIS_TVALID <= 1'b1;
        end else if (M_AXIS_TREADY) begin
            M_AXIS_TVALID <= 1'b0;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (done_valid && done_ready) begin
            M_AXIS_TDATA <= maj;
        end
    end

    // beat holds steady under back-pressure
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        M_AXIS_TVALID && !M_AXIS_TREADY |=> M_AXIS_TVALID && $stable(M_AXIS_TDATA));

endmodule

`default_nettype wire

/* hdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_top #(
    parameter int           NUM_CORES  = 4,
    parameter int           ITEM_DEPTH = 256,
    parameter hdc_pkg::hv_t SEED       = 32'h2545_f491
) (
    input  logic                                  AXIS_ACLK,
    input  logic                                  S_AXI_ARESETN,
    // AXI-Lite control
    input  logic [31:0]                           S_AXI_AWADDR,
    input  logic                                  S_AXI_AWVALID,
    output logic                                  S_AXI_AWREADY,
    input  logic [31:0]                           S_AXI_WDATA,
    input  logic [3:0]                            S_AXI_WSTRB,
    input  logic                                  S_AXI_WVALID,
    output logic                                  S_AXI_WREADY,
    output logic [1:0]                            S_AXI_BRESP,
    output logic                                  S_AXI_BVALID,
    input  logic                                  S_AXI_BREADY,
    input  logic [31:0]                           S_AXI_ARADDR,
    input  logic                                  S_AXI_ARVALID,
    output logic                                  S_AXI_ARREADY,
    output logic [31:0]                           S_AXI_RDATA,
    output logic [1:0]                            S_AXI_RRESP,
    output logic                                  S_AXI_RVALID,
    input  logic                                  S_AXI_RREADY,
    // index stream in, one index per lane
    input  logic [NUM_CORES*hdc_pkg::INDEX_W-1:0] S_AXIS_TDATA,
    input  logic                                  S_AXIS_TVALID,
    input  logic                                  S_AXIS_TLAST,
    output logic                                  S_AXIS_TREADY,
    // bundled hypervectors out, one per lane
    output logic [NUM_CORES*hdc_pkg::DIM-1:0]     M_AXIS_TDATA,
    output logic                                  M_AXIS_TVALID,
    input  logic                                  M_AXIS_TREADY
);
    import hdc_pkg::*;

    // control
    logic   run;
    logic   gen;
    index_t item_count;
    logic   gen_done;

    // generator to memory
    logic   wr_en;
    index_t wr_index;
    hv_t    wr_vec;
    hv_t    tie_vec;

    // lookup and finished packet
    logic [NUM_CORES*INDEX_W-1:0]     rd_index;
    logic [NUM_CORES*DIM-1:0]         rd_vec;
    logic [NUM_CORES*DIM*CNT_W-1:0]   counts;
    logic [CNT_W-1:0]                 sample_num;
    logic                             done_valid;
    logic                             done_ready;

    // ======================================================================
    // stages, ports connect by matching names
    // ======================================================================

    hdc_regs hdc_regs_i (.*);

    item_gen #(
        .SEED(SEED)
    ) item_gen_i (.*);

    item_memory #(
        .NUM_CORES (NUM_CORES),
        .ITEM_DEPTH(ITEM_DEPTH)
    ) item_memory_i (.*);

    bundle_accum #(
        .NUM_CORES(NUM_CORES)
    ) bundle_accum_i (.*);

    majority_out #(
        .NUM_CORES(NUM_CORES)
    ) majority_out_i (.*);

endmodule

`default_nettype wire

/* tb_hdc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hdc;
    import hdc_pkg::*;

    localparam int NUM_CORES = 4;
    localparam int CLK_HALF  = 10;
    localparam int MAX_PKTS  = 32;

    // byte addresses of the register words
    localparam logic [31:0] ADDR_CTRL     = {20'd0, REG_CTRL, 2'b00};
    localparam logic [31:0] ADDR_COUNT    = {20'd0, REG_COUNT, 2'b00};
    localparam logic [31:0] ADDR_UNMAPPED = 32'h0000_0010;
    // gen sits in ctrl bit 0 and run in bit 1
    localparam logic [31:0] CTRL_GEN      = 32'h0000_0001;
    localparam logic [31:0] CTRL_RUN      = 32'h0000_0002;

    logic                         AXIS_ACLK;
    logic                         S_AXI_ARESETN;
    logic [31:0]                  S_AXI_AWADDR;
    logic                         S_AXI_AWVALID;
    logic                         S_AXI_AWREADY;
    logic [31:0]                  S_AXI_WDATA;
    logic [3:0]                   S_AXI_WSTRB;
    logic                         S_AXI_WVALID;
    logic                         S_AXI_WREADY;
    logic [1:0]                   S_AXI_BRESP;
    logic                         S_AXI_BVALID;
    logic                         S_AXI_BREADY;
    logic [31:0]                  S_AXI_ARADDR;
    logic                         S_AXI_ARVALID;
    logic                         S_AXI_ARREADY;
    logic [31:0]                  S_AXI_RDATA;
    logic [1:0]                   S_AXI_RRESP;
    logic                         S_AXI_RVALID;
    logic                         S_AXI_RREADY;
    logic [NUM_CORES*INDEX_W-1:0] S_AXIS_TDATA;
    logic                         S_AXIS_TVALID;
    logic                         S_AXIS_TLAST;
    logic                         S_AXIS_TREADY;
    logic [NUM_CORES*DIM-1:0]     M_AXIS_TDATA;
    logic                         M_AXIS_TVALID;
    logic                         M_AXIS_TREADY;

    // raw words of the data file
    logic [31:0] tdata_mem [0:255];
    int          pkt_beats [0:MAX_PKTS-1];
    int          pkt_first [0:MAX_PKTS-1];
    int          item_total;
    int          num_pkts;
    int          watch_cycles = 0;
    int          cycle_cnt = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    hdc_top #(
        .NUM_CORES(NUM_CORES)
    ) hdc_top_i (.*);

    always #CLK_HALF AXIS_ACLK = ~AXIS_ACLK;

    always @(posedge AXIS_ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ======================================================================
    // AXI-Lite master
    // ======================================================================

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge AXIS_ACLK);
        S_AXI_AWADDR  <= addr;
        S_AXI_AWVALID <= 1'b1;
        S_AXI_WDATA   <= data;
        S_AXI_WVALID  <= 1'b1;
        S_AXI_BREADY  <= 1'b1;
        // each channel drops once its ready was seen
        while (!(aw_done && w_done)) begin
            @(negedge AXIS_ACLK);
            aw_done = aw_done || S_AXI_AWREADY;
            w_done  = w_done || S_AXI_WREADY;
            @(posedge AXIS_ACLK);
            if (aw_done) begin
                S_AXI_AWVALID <= 1'b0;
            end
            if (w_done) begin
                S_AXI_WVALID <= 1'b0;
            end
        end
        do begin
            @(negedge AXIS_ACLK);
        end while (!S_AXI_BVALID);
        if (S_AXI_BRESP !== RESP_OKAY) begin
            $display("mismatch at %0t: write to %h gave BRESP %b", $time, addr, S_AXI_BRESP);
            test_errs++;
        end
        @(posedge AXIS_ACLK);
        S_AXI_BREADY <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge AXIS_ACLK);
        S_AXI_ARADDR  <= addr;
        S_AXI_ARVALID <= 1'b1;
        S_AXI_RREADY  <= 1'b1;
        do begin
            @(negedge AXIS_ACLK);
        end while (!S_AXI_ARREADY);
        @(posedge AXIS_ACLK);
        S_AXI_ARVALID <= 1'b0;
        // one fetch cycle, then data waits for us
        do begin
            @(negedge AXIS_ACLK);
        end while (!S_AXI_RVALID);
        data = S_AXI_RDATA;
        if (S_AXI_RRESP !== RESP_OKAY) begin
            $display("mismatch at %0t: read of %h gave RRESP %b", $time, addr, S_AXI_RRESP);
            test_errs++;
        end
        @(posedge AXIS_ACLK);
        S_AXI_RREADY <= 1'b0;
    endtask

    // ======================================================================
    // streams
    // ======================================================================

    task automatic send_packets(input int first, input int last, input logic gaps);
        int gap;
        @(posedge AXIS_ACLK);
        for (int p = first; p <= last; p++) begin
            for (int b = 0; b < pkt_beats[p]; b++) begin
                if (gaps) begin
                    gap = int'($urandom_range(3, 0));
                    S_AXIS_TVALID <= 1'b0;
                    repeat (gap) @(posedge AXIS_ACLK);
                end
                S_AXIS_TDATA  <= tdata_mem[pkt_first[p] + b];
                S_AXIS_TVALID <= 1'b1;
                S_AXIS_TLAST  <= (b == pkt_beats[p] - 1);
                do begin
                    @(negedge AXIS_ACLK);
                end while (!S_AXIS_TREADY);
                // beat taken on this edge
                @(posedge AXIS_ACLK);
            end
        end
        S_AXIS_TVALID <= 1'b0;
        S_AXIS_TLAST  <= 1'b0;
    endtask

    task automatic recv_packets(input int first, input int last, input logic stall);
        logic                     taken;
        logic [NUM_CORES*DIM-1:0] got;
        logic [31:0]              exp;
        @(posedge AXIS_ACLK);
        for (int p = first; p <= last; p++) begin
            taken = 1'b0;
            while (!taken) begin
                // ready about three cycles out of four under back-pressure
                M_AXIS_TREADY <= stall ? ($urandom_range(3, 0) != 0) : 1'b1;
                @(negedge AXIS_ACLK);
                taken = M_AXIS_TVALID && M_AXIS_TREADY;
                got   = M_AXIS_TDATA;
                @(posedge AXIS_ACLK);
            end
            // expected words follow the beats with lane 0 first
            for (int lane = 0; lane < NUM_CORES; lane++) begin
                exp = tdata_mem[pkt_first[p] + pkt_beats[p] + lane];
                if (got[lane*DIM +: DIM] !== exp) begin
                    $display("mismatch at %0t: packet %0d lane %0d got %h expected %h",
                             $time, p, lane, got[lane*DIM +: DIM], exp);
                    test_errs++;
                end
            end
        end
        M_AXIS_TREADY <= 1'b1;
    endtask

    task automatic run_packets(input int first, input int last, input logic random_gaps);
        fork
            send_packets(first, last, random_gaps);
            recv_packets(first, last, random_gaps);
        join
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: failed with %0d errors", tests_run, name, test_errs);
        end
        test_errs = 0;
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        logic [31:0] rd;
        int          pos;
        int          start;
        void'($urandom(32'h7e7c_a25c));
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = 4'hf;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        S_AXIS_TDATA  = '0;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        M_AXIS_TREADY = 1'b0;

        // item count and packet count come first, then the packets back to back
        $readmemh("hdc_testdata.txt", tdata_mem);
        item_total = int'(tdata_mem[0]);
        num_pkts   = int'(tdata_mem[1]);
        pos        = 2;
        for (int p = 0; p < num_pkts; p++) begin
            pkt_beats[p] = int'(tdata_mem[pos]);
            pkt_first[p] = pos + 1;
            pos          = pos + 1 + pkt_beats[p] + NUM_CORES;
        end
        // each packet runs twice, plus generation and register traffic
        watch_cycles = 400 * num_pkts + item_total + 2 + 600;

        repeat (10) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        // test 1 covers the registers
        @(negedge AXIS_ACLK);
        if ((S_AXI_BVALID !== 1'b0) || (S_AXI_RVALID !== 1'b0)
                || (S_AXIS_TREADY !== 1'b0) || (M_AXIS_TVALID !== 1'b0)) begin
            $display("a valid or ready output is not low right after reset");
            test_errs++;
        end
        axi_write(ADDR_COUNT, 32'(item_total));
        axi_read(ADDR_COUNT, rd);
        if (rd !== 32'(item_total)) begin
            $display("mismatch at %0t: count reads %h expected %h", $time, rd, item_total);
            test_errs++;
        end
        axi_write(ADDR_CTRL, CTRL_RUN);
        axi_read(ADDR_CTRL, rd);
        if (rd !== CTRL_RUN) begin
            $display("mismatch at %0t: ctrl reads %h expected %h", $time, rd, CTRL_RUN);
            test_errs++;
        end
        axi_write(ADDR_CTRL, 32'd0);
        axi_read(ADDR_UNMAPPED, rd);
        if (rd !== 32'd0) begin
            $display("mismatch at %0t: unmapped word reads %h expected 0", $time, rd);
            test_errs++;
        end
        finish_test("register access");

        // test 2 sets run along with gen so only gen holds the input stream off
        axi_write(ADDR_CTRL, CTRL_GEN | CTRL_RUN);
        start = cycle_cnt;
        // gen stays high for at least item_count cycles after the write
        repeat (item_total) begin
            @(negedge AXIS_ACLK);
            if (S_AXIS_TREADY) begin
                $display("input stream ready while items are being generated");
                test_errs++;
            end
        end
        rd = CTRL_GEN;
        while ((rd[0] === 1'b1) && (cycle_cnt - start <= item_total + 10)) begin
            axi_read(ADDR_CTRL, rd);
        end
        if (rd[0] !== 1'b0) begin
            $display("gen bit still set %0d cycles after it was written", cycle_cnt - start);
            test_errs++;
        end
        @(negedge AXIS_ACLK);
        if (!S_AXIS_TREADY) begin
            $display("input stream not ready once gen cleared with run set");
            test_errs++;
        end
        axi_write(ADDR_CTRL, 32'd0);
        @(negedge AXIS_ACLK);
        if (S_AXIS_TREADY) begin
            $display("input stream ready before run is set");
            test_errs++;
        end
        axi_write(ADDR_CTRL, CTRL_RUN);
        @(negedge AXIS_ACLK);
        if (!S_AXIS_TREADY) begin
            $display("input stream not ready with run set and gen clear");
            test_errs++;
        end
        finish_test("item generation");

        // tests 3 to 5 run without gaps or back-pressure
        for (int p = 0; p < num_pkts; p++) begin
            if (pkt_beats[p] == 1) begin
                run_packets(p, p, 1'b0);
            end
        end
        finish_test("single-beat packets");
        for (int p = 0; p < num_pkts; p++) begin
            if ((pkt_beats[p] > 1) && (pkt_beats[p] % 2 == 1)) begin
                run_packets(p, p, 1'b0);
            end
        end
        finish_test("odd-length packets");
        for (int p = 0; p < num_pkts; p++) begin
            if (pkt_beats[p] % 2 == 0) begin
                run_packets(p, p, 1'b0);
            end
        end
        finish_test("even-length packets with ties");

        // test 6 repeats all packets with random gaps and stalls
        run_packets(0, num_pkts - 1, 1'b1);
        repeat (20) begin
            @(negedge AXIS_ACLK);
            if (M_AXIS_TVALID) begin
                $display("an extra output beat appeared after the last packet");
                test_errs++;
            end
        end
        finish_test("back-pressure");

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog armed once the data file is parsed
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge AXIS_ACLK);
        $display("timeout: the run did not finish within %0d cycles", watch_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdc_testdata.txt */
// item count and packet count, then per packet: beat count, one word per beat
// (lane 0 index in the low byte), then the expected hypervectors of lanes 0 to 3
00000003 00000005
// single beat, items 0 1 2 0
00000001 00020100
E124B63A 8B9A74AB 64E1B3AC E124B63A
// single beat, items 2 2 1 0
00000001 00010202
64E1B3AC 64E1B3AC 8B9A74AB E124B63A
// three beats, lanes 0 to 2 see items 0 1 2, lane 3 sees 0 0 1
00000003 00020100 00000201 01010002
E1A0B6AA E1A0B6AA E1A0B6AA E124B63A
// five beats, lanes 0 and 3 see 0 0 1 1 2, lane 1 sees 1 1 1 2 2, lane 2 all 2
00000005 00020100 01020101 00020102 01020200 02020201
E1A0B6AA 8B9A74AB 64E1B3AC E1A0B6AA
// two beats, lanes see 0+1, 1+2, 0+2 and 2+2, tie vector 00174626
00000002 02000100 02020201
8116762A 009376AE 6025B62E 64E1B3AC

/* sim.f */
hdc_pkg.sv
hdc_regs.sv
item_gen.sv
item_memory.sv
bundle_accum.sv
majority_out.sv
hdc_top.sv
tb_hdc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f sim.f --top-module tb_hdc -o tb_hdc > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_hdc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
exit 1
